/* Makefile */
# Verilator build for the digital clock testbench
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= clock_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/clock_properties.sv */
`timescale 1ns/1ps

module clock_properties #(
	parameter bit CTRL = 1'b1	// 1 on the controller, 0 on the scanner
) (
	input logic		clk,
	input logic		rst_n,
	input logic [5:0]	inc,
	input logic [1:0]	mode,
	input logic [5:0]	seg_enb
);

	// one strobe at most
	a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		!CTRL || $onehot0(inc))
		else $error("more than one increment strobe high");

	a_mode_legal: assert property (@(posedge clk) disable iff (!rst_n)
		!CTRL || (mode != 2'd3))
		else $error("mode register holds an undefined value");

	a_one_digit: assert property (@(posedge clk) disable iff (!rst_n)
		CTRL || $onehot(~seg_enb))
		else $error("digit enable does not have exactly one low bit");

endmodule

bind mode_ctrl clock_properties #(.CTRL(1'b1)) u_ctrl_props (
	.clk	(clk),
	.rst_n	(rst_n),
	.inc	({set_bus.sec_inc, set_bus.min_inc, set_bus.hr_inc,
		  set_bus.alm_sec_inc, set_bus.alm_min_inc, set_bus.alm_hr_inc}),
	.mode	(mode),
	.seg_enb	(6'h3e)
);

bind digit_scan clock_properties #(.CTRL(1'b0)) u_scan_props (
	.clk	(clk),
	.rst_n	(rst_n),
	.inc	(6'h00),
	.mode	(2'd0),
	.seg_enb	(o_seg_enb)
);

/* testbench/clock_tb.sv */
`timescale 1ns/1ps

module clock_tb
	import clock_pkg::*, display_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int TICK_DIV   = 16;
	localparam int SCAN_DIV   = 4;
	localparam int DAY_SECS   = 86400;
	// 3725 seconds of free run plus room for the short tests
	localparam int RUN_CYCLES = 3725 * TICK_DIV + 15000;
	localparam int B_MODE = 0;
	localparam int B_POS  = 1;
	localparam int B_INC  = 2;
	localparam int B_ALM  = 3;

	logic		clk;
	logic		rst_n;
	logic [3:0]	btn;
	seg_t		o_seg;
	seg_enb_t	o_seg_enb;
	logic		o_alarm;

	// reference state
	int		exp_t;
	int		exp_alm;
	mode_t		exp_mode;
	pos_t		exp_pos;
	logic		exp_en;
	logic		exp_alarm;
	int		tick_cnt;
	int		scan_cnt;
	int		exp_idx;
	logic [3:0]	s1;
	logic [3:0]	s2;
	logic [3:0]	s3;

	int		errors = 0;
	int		failed = 0;
	int		seed = 32'ha73d_9110;
	int		rd_h;
	int		rd_m;
	int		rd_s;

	clock_top #(.TICK_DIV(TICK_DIV), .SCAN_DIV(SCAN_DIV)) dut (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_btn_mode	(btn[B_MODE]),
		.i_btn_pos	(btn[B_POS]),
		.i_btn_inc	(btn[B_INC]),
		.i_btn_alm_en	(btn[B_ALM]),
		.o_seg		(o_seg),
		.o_seg_enb	(o_seg_enb),
		.o_alarm	(o_alarm)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// ------------------------------
	// reference model
	// ------------------------------
	function automatic int inc_field(input int t, input pos_t p);
		int h;
		int m;
		int s;
		h = t / 3600;
		m = (t / 60) % 60;
		s = t % 60;
		case (p)
			POS_SEC: s = (s + 1) % 60;	// no carry while setting
			POS_MIN: m = (m + 1) % 60;
			default: h = (h + 1) % 24;
		endcase
		return h * 3600 + m * 60 + s;
	endfunction

	function automatic int digit_of(input int t, input int idx);
		int h;
		int m;
		int s;
		h = t / 3600;
		m = (t / 60) % 60;
		s = t % 60;
		case (idx)
			0: return s % 10;
			1: return s / 10;
			2: return m % 10;
			3: return m / 10;
			4: return h % 10;
			default: return h / 10;
		endcase
	endfunction

	// only the selected digit has its enable low
	function automatic seg_enb_t enable_pattern(input int idx);
		seg_enb_t enb;
		for (int b = 0; b < NUM_DIGITS; b++) begin
			enb[b] = (b != idx);
		end
		return enb;
	endfunction

	function automatic int seg_to_digit(input seg_t seg);
		case (seg)
			7'h7e: return 0;
			7'h30: return 1;
			7'h6d: return 2;
			7'h79: return 3;
			7'h33: return 4;
			7'h5b: return 5;
			7'h5f: return 6;
			7'h70: return 7;
			7'h7f: return 8;
			7'h73: return 9;
			default: return 15;	// not a digit
		endcase
	endfunction

	always @(posedge clk or negedge rst_n) begin
		logic [3:0]	p;
		logic		n_alarm;
		if (!rst_n) begin
			exp_t     = 0;
			exp_alm   = 0;
			exp_mode  = CLOCK_MODE;
			exp_pos   = POS_SEC;
			exp_en    = 1'b0;
			exp_alarm = 1'b0;
			tick_cnt  = 0;
			scan_cnt  = 0;
			exp_idx   = 0;
			s1 = '0;
			s2 = '0;
			s3 = '0;
		end else begin
			p = s2 & ~s3;	// press after two sync stages and edge detect
			n_alarm = exp_en && ((exp_t == exp_alm) || exp_alarm);
			if (tick_cnt == TICK_DIV - 1) begin
				tick_cnt = 0;
				if (exp_mode != SETUP_MODE) exp_t = (exp_t + 1) % DAY_SECS;
			end else begin
				tick_cnt = tick_cnt + 1;
			end
			if (scan_cnt == SCAN_DIV - 1) begin
				scan_cnt = 0;
				exp_idx  = (exp_idx + 1) % NUM_DIGITS;
			end else begin
				scan_cnt = scan_cnt + 1;
			end
			if (p[B_INC] && exp_mode == SETUP_MODE) exp_t = inc_field(exp_t, exp_pos);
			if (p[B_INC] && exp_mode == ALARM_MODE) exp_alm = inc_field(exp_alm, exp_pos);
			if (p[B_MODE]) begin
				case (exp_mode)
					CLOCK_MODE: exp_mode = SETUP_MODE;
					SETUP_MODE: exp_mode = ALARM_MODE;
					default:    exp_mode = CLOCK_MODE;
				endcase
			end
			if (p[B_POS]) begin
				case (exp_pos)
					POS_SEC: exp_pos = POS_MIN;
					POS_MIN: exp_pos = POS_HR;
					default: exp_pos = POS_SEC;
				endcase
			end
			if (p[B_ALM]) exp_en = ~exp_en;
			exp_alarm = n_alarm;
			s3 = s2;
			s2 = s1;
			s1 = btn;
		end
	end

	// ------------------------------
	// compare on every falling edge
	// ------------------------------
	always @(negedge clk) begin
		int want;
		int got;
		if (rst_n) begin
			assert (o_alarm === exp_alarm) else begin
				$display("ERR o_alarm expected %h got %h", exp_alarm, o_alarm);
				errors++;
			end
			assert (o_seg_enb === enable_pattern(exp_idx)) else begin
				$display("ERR o_seg_enb expected %h got %h", enable_pattern(exp_idx),
					o_seg_enb);
				errors++;
			end
			want = digit_of((exp_mode == ALARM_MODE) ? exp_alm : exp_t, exp_idx);
			got  = seg_to_digit(o_seg);
			assert (got == want) else begin
				$display("ERR o_seg digit %0d expected %h got %h", exp_idx, want, got);
				errors++;
			end
		end
	end

	initial begin
		#(RUN_CYCLES * CLK_PERIOD);
		$display("timeout: the tests did not finish in the expected time");
		$display("tests failed");
		$finish;
	end

	// ------------------------------
	// tasks
	// ------------------------------
	task automatic apply_reset();
		rst_n <= 1'b0;
		repeat (5) @(negedge clk);
		rst_n <= 1'b1;
	endtask

	task automatic press(input int b);
		btn[b] <= 1'b1;
		repeat (4) @(negedge clk);
		btn[b] <= 1'b0;
		repeat (4) @(negedge clk);
	endtask

	task automatic goto_pos(input pos_t p);
		while (exp_pos != p) press(B_POS);
	endtask

	// rebuild the shown time from one full scan
	task automatic read_display(output int h, output int m, output int s);
		int d [NUM_DIGITS];
		int wait_cnt;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			wait_cnt = 0;
			while (o_seg_enb !== enable_pattern(i) && wait_cnt < 8 * SCAN_DIV) begin
				@(negedge clk);
				wait_cnt++;
			end
			if (wait_cnt >= 8 * SCAN_DIV) begin
				$display("digit %0d was never selected by the scan", i);
				errors++;
			end
			d[i] = seg_to_digit(o_seg);
			assert (d[i] < 10) else begin
				$display("ERR o_seg not a digit, pattern %h", o_seg);
				errors++;
			end
		end
		s = d[1] * 10 + d[0];
		m = d[3] * 10 + d[2];
		h = d[5] * 10 + d[4];
	endtask

	task automatic check_time(input string sig, input int t, input int h, input int m,
			input int s);
		assert (h == t / 3600 && m == (t / 60) % 60 && s == t % 60) else begin
			$display("ERR %s expected %h:%h:%h got %h:%h:%h", sig, t / 3600,
				(t / 60) % 60, t % 60, h, m, s);
			errors++;
		end
	endtask

	task automatic set_time(input int tgt);
		int n;
		goto_pos(POS_SEC);
		n = (tgt % 60 - exp_t % 60 + 60) % 60;
		repeat (n) press(B_INC);
		goto_pos(POS_MIN);
		n = ((tgt / 60) % 60 - (exp_t / 60) % 60 + 60) % 60;
		repeat (n) press(B_INC);
		goto_pos(POS_HR);
		n = (tgt / 3600 - exp_t / 3600 + 24) % 24;
		repeat (n) press(B_INC);
	endtask

	task automatic wait_alarm(input logic level, input int max_cycles);
		int n;
		n = 0;
		while (o_alarm !== level && n < max_cycles) begin
			@(negedge clk);
			n++;
		end
		if (o_alarm !== level) begin
			$display("o_alarm did not reach level %0d in %0d cycles", level, max_cycles);
			errors++;
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			failed++;
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		int e;
		int t0;
		int prev;
		logic [31:0] r;
		rst_n = 1'b0;
		btn   = '0;

		e = errors;	// reset state read while frozen in setup
		apply_reset();
		press(B_MODE);
		read_display(rd_h, rd_m, rd_s);
		check_time("display", 0, rd_h, rd_m, rd_s);
		assert (o_alarm === 1'b0) else begin
			$display("ERR o_alarm expected %h got %h", 1'b0, o_alarm);
			errors++;
		end
		end_test("reset", e);

		e = errors;	// free run frozen right after the target second
		apply_reset();
		do @(negedge clk); while (exp_t != 3725);
		press(B_MODE);
		read_display(rd_h, rd_m, rd_s);
		check_time("display", 3725, rd_h, rd_m, rd_s);
		end_test("free run", e);

		e = errors;	// minute and hour wraps in setup
		prev = exp_t;
		goto_pos(POS_MIN);
		repeat (61) press(B_INC);
		read_display(rd_h, rd_m, rd_s);
		check_time("display", prev - (prev / 60 % 60) * 60 + ((prev / 60 + 1) % 60) * 60,
			rd_h, rd_m, rd_s);
		prev = exp_t;
		goto_pos(POS_HR);
		repeat (25) press(B_INC);
		read_display(rd_h, rd_m, rd_s);
		check_time("display", prev % 3600 + ((prev / 3600 + 1) % 24) * 3600,
			rd_h, rd_m, rd_s);
		end_test("setup", e);

		e = errors;	// alarm setting while time runs
		press(B_MODE);
		t0 = exp_t;
		goto_pos(POS_HR);
		repeat (2) press(B_INC);
		goto_pos(POS_SEC);
		repeat (10) press(B_INC);
		read_display(rd_h, rd_m, rd_s);
		check_time("alarm display", 2 * 3600 + 10, rd_h, rd_m, rd_s);
		press(B_MODE);	// back to clock mode
		press(B_MODE);	// freeze in setup to read the running time
		read_display(rd_h, rd_m, rd_s);
		check_time("display", exp_t, rd_h, rd_m, rd_s);
		assert (rd_h * 3600 + rd_m * 60 + rd_s != t0) else begin
			$display("running time did not advance during alarm setting");
			errors++;
		end
		end_test("alarm set", e);

		e = errors;	// alarm match with hold and clear
		set_time((exp_alm - 6 + DAY_SECS) % DAY_SECS);
		press(B_ALM);
		press(B_MODE);
		press(B_MODE);
		wait_alarm(1'b1, 20 * TICK_DIV);
		repeat (5 * TICK_DIV) @(negedge clk);
		assert (o_alarm === 1'b1) else begin
			$display("ERR o_alarm expected %h got %h", 1'b1, o_alarm);
			errors++;
		end
		press(B_ALM);
		wait_alarm(1'b0, 10);
		end_test("alarm match", e);

		e = errors;	// seeded random presses
		press(B_MODE);
		for (int i = 0; i < 40; i++) begin
			if (i == 20) begin
				read_display(rd_h, rd_m, rd_s);
				check_time("display", exp_t, rd_h, rd_m, rd_s);
				press(B_MODE);
			end
			r = $random(seed);
			press(r[0] ? B_POS : B_INC);
		end
		read_display(rd_h, rd_m, rd_s);
		check_time("alarm display", exp_alm, rd_h, rd_m, rd_s);
		end_test("random", e);

		$display("summary: 6 run, %0d with errors, %0d check errors", failed, errors);
		if (errors == 0 && failed == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* verilog/clock_pkg.sv */
package clock_pkg;

	// one hours, minutes or seconds value
	typedef logic [5:0] field_t;

	typedef enum logic [1:0] {
		CLOCK_MODE = 2'd0,	// running clock
		SETUP_MODE = 2'd1,	// time frozen, buttons set it
		ALARM_MODE = 2'd2	// buttons set the alarm
	} mode_t;

	// field that the increment button changes
	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HR  = 2'd2
	} pos_t;

	// ------------------------------
	// field limits
	// ------------------------------
	localparam field_t SEC_MAX = 6'd59;
	localparam field_t MIN_MAX = 6'd59;
	localparam field_t HR_MAX  = 6'd23;	// 24 hour count

endpackage

/* verilog/clock_top.sv */
`timescale 1ns/1ps

module clock_top
	import clock_pkg::*, display_pkg::*;
#(
	parameter int TICK_DIV = 50_000_000,	// clk cycles per second
	parameter int SCAN_DIV = 5_000		// clk cycles per digit
) (
	input  logic		clk,
	input  logic		rst_n,
	input  logic		i_btn_mode,
	input  logic		i_btn_pos,
	input  logic		i_btn_inc,
	input  logic		i_btn_alm_en,
	output seg_t		o_seg,
	output seg_enb_t	o_seg_enb,
	output logic		o_alarm
);

	logic	alm_en;
	field_t	disp_hr;
	field_t	disp_min;
	field_t	disp_sec;

	time_set_if set_bus ();

	// ------------------------------
	// buttons to strobes
	// ------------------------------
	mode_ctrl u_mode_ctrl (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_btn_mode	(i_btn_mode),
		.i_btn_pos	(i_btn_pos),
		.i_btn_inc	(i_btn_inc),
		.i_btn_alm_en	(i_btn_alm_en),
		.o_alm_en	(alm_en),
		.set_bus	(set_bus.ctrl)
	);

	time_keeper #(
		.TICK_DIV	(TICK_DIV)
	) u_time_keeper (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_alm_en	(alm_en),
		.set_bus	(set_bus.keeper),
		.o_hr		(disp_hr),
		.o_min		(disp_min),
		.o_sec		(disp_sec),
		.o_alarm	(o_alarm)
	);

	// display scan
	digit_scan #(
		.SCAN_DIV	(SCAN_DIV)
	) u_digit_scan (
		.clk		(clk),
		.rst_n		(rst_n),
		.i_hr		(disp_hr),
		.i_min		(disp_min),
		.i_sec		(disp_sec),
		.o_seg		(o_seg),
		.o_seg_enb	(o_seg_enb)
	);

endmodule

/* verilog/digit_scan.sv */
`timescale 1ns/1ps

module digit_scan
	import clock_pkg::*, display_pkg::*;
#(
	parameter int SCAN_DIV = 5_000
) (
	input  logic		clk,
	input  logic		rst_n,
	input  field_t		i_hr,
	input  field_t		i_min,
	input  field_t		i_sec,
	output seg_t		o_seg,
	output seg_enb_t	o_seg_enb
);

	localparam int SCAN_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
	localparam int IDX_W  = $clog2(NUM_DIGITS);

	logic [SCAN_W-1:0]	scan_cnt;
	logic			scan_en;
	logic [IDX_W-1:0]	idx;
	digit_t			digits [NUM_DIGITS];
	digit_t			sel;

	// ------------------------------
	// tens and ones per field
	// ------------------------------
	assign digits[0] = digit_t'(i_sec % 6'd10);
	assign digits[1] = digit_t'(i_sec / 6'd10);
	assign digits[2] = digit_t'(i_min % 6'd10);
	assign digits[3] = digit_t'(i_min / 6'd10);
	assign digits[4] = digit_t'(i_hr % 6'd10);
	assign digits[5] = digit_t'(i_hr / 6'd10);	// hours tens, leftmost

	// ------------------------------
	// scan rotation
	// ------------------------------
	assign scan_en = (scan_cnt == SCAN_W'(SCAN_DIV - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_cnt <= '0;
		end else if (scan_en) begin
			scan_cnt <= '0;
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idx <= '0;
		end else if (scan_en) begin
			if (idx == IDX_W'(NUM_DIGITS - 1)) begin
				idx <= '0;
			end else begin
				idx <= idx + 1'b1;
			end
		end
	end

	// selected digit and its pattern
	assign sel       = digits[idx];
	assign o_seg     = SEG_DIGIT[sel];
	assign o_seg_enb = ~(seg_enb_t'(1) << idx);	// one low bit

endmodule

/* verilog/display_pkg.sv */
package display_pkg;

	typedef logic [3:0] digit_t;	// decimal digit
	typedef logic [6:0] seg_t;	// {a, b, c, d, e, f, g}, high lights

	localparam int NUM_DIGITS = 6;

	// low selects the digit
	typedef logic [NUM_DIGITS-1:0] seg_enb_t;

	localparam seg_t SEG_BLANK = 7'b000_0000;

	// ------------------------------
	// patterns by digit code
	// ------------------------------
	localparam seg_t SEG_DIGIT [16] = '{
		7'b111_1110, 7'b011_0000, 7'b110_1101, 7'b111_1001,	// 0 to 3
		7'b011_0011, 7'b101_1011, 7'b101_1111, 7'b111_0000,	// 4 to 7
		7'b111_1111, 7'b111_0011,				// 8 and 9
		SEG_BLANK, SEG_BLANK, SEG_BLANK,			// codes above 9 stay dark
		SEG_BLANK, SEG_BLANK, SEG_BLANK
	};

endpackage

/* verilog/mode_ctrl.sv */
`timescale 1ns/1ps

module mode_ctrl
	import clock_pkg::*;
(
	input  logic		clk,
	input  logic		rst_n,
	input  logic		i_btn_mode,
	input  logic		i_btn_pos,
	input  logic		i_btn_inc,
	input  logic		i_btn_alm_en,
	output logic		o_alm_en,
	time_set_if.ctrl	set_bus
);

	localparam int BTN_MODE = 0;
	localparam int BTN_POS  = 1;
	localparam int BTN_INC  = 2;
	localparam int BTN_ALM  = 3;

	logic [3:0]	btn_raw;
	logic [3:0]	btn_sync1;
	logic [3:0]	btn_sync2;
	logic [3:0]	btn_dly;
	logic [3:0]	press;
	mode_t		mode;
	pos_t		pos;
	logic		alm_en;

	// ------------------------------
	// button synchronizers
	// ------------------------------
	assign btn_raw = {i_btn_alm_en, i_btn_inc, i_btn_pos, i_btn_mode};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			btn_sync1 <= '0;
			btn_sync2 <= '0;
			btn_dly   <= '0;
		end else begin
			btn_sync1 <= btn_raw;
			btn_sync2 <= btn_sync1;
			btn_dly   <= btn_sync2;	// edge detect
		end
	end

	assign press = btn_sync2 & ~btn_dly;	// one cycle per rising edge

	// ------------------------------
	// mode, position, alarm enable
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode   <= CLOCK_MODE;
			pos    <= POS_SEC;
			alm_en <= 1'b0;
		end else begin
			if (press[BTN_MODE]) begin
				case (mode)
					CLOCK_MODE: mode <= SETUP_MODE;
					SETUP_MODE: mode <= ALARM_MODE;
					default:    mode <= CLOCK_MODE;
				endcase
			end
			if (press[BTN_POS]) begin
				case (pos)
					POS_SEC: pos <= POS_MIN;
					POS_MIN: pos <= POS_HR;
					default: pos <= POS_SEC;
				endcase
			end
			if (press[BTN_ALM]) begin
				alm_en <= ~alm_en;
			end
		end
	end

	assign o_alm_en     = alm_en;
	assign set_bus.mode = mode;

	// increment press goes to exactly one field
	always_comb begin
		set_bus.sec_inc     = 1'b0;
		set_bus.min_inc     = 1'b0;
		set_bus.hr_inc      = 1'b0;
		set_bus.alm_sec_inc = 1'b0;
		set_bus.alm_min_inc = 1'b0;
		set_bus.alm_hr_inc  = 1'b0;
		if (press[BTN_INC]) begin
			case (mode)
				SETUP_MODE: begin
					set_bus.sec_inc = (pos == POS_SEC);
					set_bus.min_inc = (pos == POS_MIN);
					set_bus.hr_inc  = (pos == POS_HR);
				end
				ALARM_MODE: begin
					set_bus.alm_sec_inc = (pos == POS_SEC);
					set_bus.alm_min_inc = (pos == POS_MIN);
					set_bus.alm_hr_inc  = (pos == POS_HR);
				end
				default: ;	// clock mode ignores it
			endcase
		end
	end

endmodule

/* verilog/time_keeper.sv */
`timescale 1ns/1ps

module time_keeper
	import clock_pkg::*;
#(
	parameter int TICK_DIV = 50_000_000
) (
	input  logic		clk,
	input  logic		rst_n,
	input  logic		i_alm_en,
	time_set_if.keeper	set_bus,
	output field_t		o_hr,
	output field_t		o_min,
	output field_t		o_sec,
	output logic		o_alarm
);

	localparam int TICK_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [TICK_W-1:0]	tick_cnt;
	logic			tick;
	logic			adv;
	logic			sec_step;
	logic			min_step;
	logic			hr_step;
	logic			match;
	field_t			sec;
	field_t			min;
	field_t			hr;
	field_t			alm_sec;
	field_t			alm_min;
	field_t			alm_hr;

	function automatic field_t wrap_inc(input field_t val, input field_t max);
		return (val >= max) ? '0 : val + 6'd1;
	endfunction

	// ------------------------------
	// seconds tick
	// ------------------------------
	assign tick = (tick_cnt == TICK_W'(TICK_DIV - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_cnt <= '0;
		end else if (tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// time frozen while being set
	assign adv = tick && (set_bus.mode != SETUP_MODE);

	// carry chain, strobes wrap without carry
	assign sec_step = adv || set_bus.sec_inc;
	assign min_step = (adv && (sec == SEC_MAX)) || set_bus.min_inc;
	assign hr_step  = (adv && (sec == SEC_MAX) && (min == MIN_MAX)) || set_bus.hr_inc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec <= '0;
			min <= '0;
			hr  <= '0;
		end else begin
			if (sec_step) sec <= wrap_inc(sec, SEC_MAX);
			if (min_step) min <= wrap_inc(min, MIN_MAX);
			if (hr_step)  hr  <= wrap_inc(hr, HR_MAX);
		end
	end

	// ------------------------------
	// alarm time and match
	// ------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			alm_sec <= '0;
			alm_min <= '0;
			alm_hr  <= '0;
		end else begin
			if (set_bus.alm_sec_inc) alm_sec <= wrap_inc(alm_sec, SEC_MAX);
			if (set_bus.alm_min_inc) alm_min <= wrap_inc(alm_min, MIN_MAX);
			if (set_bus.alm_hr_inc)  alm_hr  <= wrap_inc(alm_hr, HR_MAX);
		end
	end

	assign match = (sec == alm_sec) && (min == alm_min) && (hr == alm_hr);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alm_en && (match || o_alarm);	// held until disabled
		end
	end

	// display shows the alarm only while setting it
	always_comb begin
		if (set_bus.mode == ALARM_MODE) begin
			o_hr  = alm_hr;
			o_min = alm_min;
			o_sec = alm_sec;
		end else begin
			o_hr  = hr;
			o_min = min;
			o_sec = sec;
		end
	end

endmodule

/* verilog/time_set_if.sv */
`timescale 1ns/1ps

interface time_set_if
	import clock_pkg::*;
();

	mode_t	mode;
	logic	sec_inc;
	logic	min_inc;
	logic	hr_inc;
	logic	alm_sec_inc;
	logic	alm_min_inc;
	logic	alm_hr_inc;

	modport ctrl (output mode, sec_inc, min_inc, hr_inc, alm_sec_inc, alm_min_inc, alm_hr_inc);
	modport keeper (input mode, sec_inc, min_inc, hr_inc, alm_sec_inc, alm_min_inc, alm_hr_inc);

endinterface

/* vlog.f */
verilog/clock_pkg.sv
verilog/display_pkg.sv
verilog/time_set_if.sv
verilog/mode_ctrl.sv
verilog/time_keeper.sv
verilog/digit_scan.sv
verilog/clock_top.sv
testbench/clock_properties.sv
testbench/clock_tb.sv
